// File: source/async_fifo_pkg.sv
////////////////////////////////////////////////////////////
// Sizes and types shared by the dual-clock FIFO
// Every design module imports this package, and so does the bench
// Depth, width and synchronizer length are changed here only
////////////////////////////////////////////////////////////

`default_nettype none

package async_fifo_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Address bits, log2 of the entry count
	localparam int FIFO_AW = 3;

	// Entry count follows from the address width
	localparam int FIFO_DEPTH = 1 << FIFO_AW;

	// Data bits per entry
	localparam int DATA_W = 16;

	// Flops per clock-domain crossing
	// Two is the minimum for a safe crossing
	localparam int SYNC_STAGES = 2;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// One FIFO entry
	typedef logic [DATA_W-1:0] data_t;

	// Storage index
	typedef logic [FIFO_AW-1:0] addr_t;

	// Binary or Gray pointer
	// Extra top bit tells a full FIFO from an empty one
	typedef logic [FIFO_AW:0] ptr_t;

	// Memory write request from the write controller
	typedef struct packed {
		logic  en;
		addr_t addr;
		data_t data;
	} mem_wr_t;

endpackage

`default_nettype wire

// File: source/gray_ptr_sync.sv
////////////////////////////////////////////////////////////
// Carries a Gray-coded FIFO pointer into another clock domain
// A chain of SYNC_STAGES flops clocked by the receiving side
// One instance per crossing direction
////////////////////////////////////////////////////////////

`default_nettype none

module gray_ptr_sync (
	// Receiving clock and its reset
	input  wire                        i_clk,
	input  wire                        i_reset_n,
	// Pointer from the sending domain
	input  wire async_fifo_pkg::ptr_t  i_gray,
	// Pointer as seen by the receiving domain
	output async_fifo_pkg::ptr_t       o_gray
);

	import async_fifo_pkg::*;

	// Stage 0 samples the foreign pointer
	// last stage is the only one the receiving logic may use
	(* ASYNC_REG = "TRUE" *) ptr_t sync_q [SYNC_STAGES];

	////////////////////////////////////////////////////////////
	// Synchronizer chain
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_reset_n)
	begin
		if (!i_reset_n)
		begin
			// All stages start at pointer zero
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			// Only one Gray bit moves at a time, so a late sample is harmless
			sync_q[0] <= i_gray;
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	// Exactly SYNC_STAGES edges of delay
	assign o_gray = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: source/fifo_ram.sv
////////////////////////////////////////////////////////////
// Storage array of the dual-clock FIFO
// Written in the write domain, read combinationally
// The read controller registers the read word
////////////////////////////////////////////////////////////

`default_nettype none

module fifo_ram (
	// Write clock
	input  wire                           i_wclk,
	// Write request from the write controller
	input  wire async_fifo_pkg::mem_wr_t  i_mem_wr,
	// Read index from the read controller
	input  wire async_fifo_pkg::addr_t    i_rd_addr,
	// Word at the read index
	output async_fifo_pkg::data_t         o_rd_data
);

	import async_fifo_pkg::*;

	// FIFO_DEPTH entries
	data_t mem [FIFO_DEPTH];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// Enable already includes the full check
	always_ff @(posedge i_wclk)
	begin
		if (i_mem_wr.en)
			mem[i_mem_wr.addr] <= i_mem_wr.data;
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Asynchronous read
	// The slot under the read pointer is never the one being written
	// unless the FIFO is empty, and then the word is not used
	assign o_rd_data = mem[i_rd_addr];

endmodule

`default_nettype wire

// File: source/fifo_wr_ctrl.sv
////////////////////////////////////////////////////////////
// Write side of the dual-clock FIFO
// Keeps the binary and Gray write pointers, raises the full flag
// and issues the memory write for each accepted word
////////////////////////////////////////////////////////////

`default_nettype none

module fifo_wr_ctrl (
	// Write clock and its reset
	input  wire                        i_wclk,
	input  wire                        i_wr_reset_n,
	// Writer strobe and data
	input  wire                        i_wr,
	input  wire async_fifo_pkg::data_t i_wr_data,
	// Gray read pointer after the crossing
	input  wire async_fifo_pkg::ptr_t  i_rgray_sync,
	// Back-pressure to the writer
	output logic                       o_wr_full,
	// Write request to the storage
	output async_fifo_pkg::mem_wr_t    o_mem_wr,
	// Gray write pointer toward the read domain
	output async_fifo_pkg::ptr_t       o_wgray
);

	import async_fifo_pkg::*;

	// Binary write pointer with its wrap bit
	ptr_t wr_ptr;
	ptr_t wr_ptr_next;

	// Registered Gray copy, the only thing that crosses
	ptr_t wgray;
	ptr_t wgray_next;

	// Read pointer as it would look when the FIFO is full
	ptr_t full_match;

	// A write that the FIFO takes
	logic wr_accept;

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	// Writes while full are dropped here
	assign wr_accept = i_wr && !o_wr_full;

	assign wr_ptr_next = wr_ptr + 1'b1;

	// Binary to Gray of the next pointer
	assign wgray_next = wr_ptr_next ^ (wr_ptr_next >> 1);

	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wr_ptr <= '0;
			wgray  <= '0;
		end
		else if (wr_accept)
		begin
			// Both advance together on the accepting edge
			wr_ptr <= wr_ptr_next;
			wgray  <= wgray_next;
		end
	end

	assign o_wgray = wgray;

	////////////////////////////////////////////////////////////
	// Full flag
	////////////////////////////////////////////////////////////

	// In Gray code a pointer one lap behind differs in its top two bits
	assign full_match = {~wgray[FIFO_AW:FIFO_AW-1], wgray[FIFO_AW-2:0]};

	// Stale read pointer only keeps full high longer
	assign o_wr_full = (i_rgray_sync == full_match);

	////////////////////////////////////////////////////////////
	// Memory write
	////////////////////////////////////////////////////////////

	// Low pointer bits select the slot
	always_comb
	begin
		o_mem_wr.en   = wr_accept;
		o_mem_wr.addr = wr_ptr[FIFO_AW-1:0];
		o_mem_wr.data = i_wr_data;
	end

endmodule

`default_nettype wire

// File: source/fifo_rd_ctrl.sv
////////////////////////////////////////////////////////////
// Read side of the dual-clock FIFO
// Keeps the binary and Gray read pointers and a registered
// output word that acts as a one-entry prefetch stage
////////////////////////////////////////////////////////////

`default_nettype none

module fifo_rd_ctrl (
	// Read clock and its reset
	input  wire                        gbl_clk,
	input  wire                        i_rd_reset_n,
	// Reader strobe
	input  wire                        i_rd,
	// Gray write pointer after the crossing
	input  wire async_fifo_pkg::ptr_t  i_wgray_sync,
	// Word at the read index
	input  wire async_fifo_pkg::data_t i_ram_data,
	// Read index into the storage
	output async_fifo_pkg::addr_t      o_ram_addr,
	// Gray read pointer toward the write domain
	output async_fifo_pkg::ptr_t       o_rgray,
	// Oldest word and its valid flag
	output async_fifo_pkg::data_t      o_rd_data,
	output logic                       o_rd_empty
);

	import async_fifo_pkg::*;

	// Binary read pointer with its wrap bit
	ptr_t rd_ptr;
	ptr_t rd_ptr_next;

	// Registered Gray copy sent across
	ptr_t rgray;
	ptr_t rgray_next;

	// Storage holds nothing beyond the output register
	logic empty_int;

	// Output register takes a new word this edge
	logic fetch;

	// Fetch that finds a word in the storage
	logic advance;

	////////////////////////////////////////////////////////////
	// Internal empty and fetch control
	////////////////////////////////////////////////////////////

	// Equal Gray pointers mean nothing left to fetch
	assign empty_int = (i_wgray_sync == rgray);

	// Load when the output is free or being consumed
	assign fetch = o_rd_empty || i_rd;

	// Pointer moves only when the fetch pulls a real word
	assign advance = fetch && !empty_int;

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	assign rd_ptr_next = rd_ptr + 1'b1;

	// Binary to Gray of the next pointer
	assign rgray_next = rd_ptr_next ^ (rd_ptr_next >> 1);

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rd_ptr <= '0;
			rgray  <= '0;
		end
		else if (advance)
		begin
			rd_ptr <= rd_ptr_next;
			rgray  <= rgray_next;
		end
	end

	assign o_ram_addr = rd_ptr[FIFO_AW-1:0];
	assign o_rgray    = rgray;

	////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////

	// Empty until the first fetch finds data
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			o_rd_empty <= 1'b1;
		else if (fetch)
			o_rd_empty <= empty_int;
	end

	// Word held while the reader waits
	// a fetch from an empty storage loads a don't-care word
	always_ff @(posedge gbl_clk)
	begin
		if (fetch)
			o_rd_data <= i_ram_data;
	end

endmodule

`default_nettype wire

// File: source/async_fifo.sv
////////////////////////////////////////////////////////////
// Dual-clock FIFO top level
// Writer lives on i_wclk, reader on gbl_clk
// Gray pointers cross through two synchronizers
////////////////////////////////////////////////////////////

`default_nettype none

module async_fifo (
	// Write side in the i_wclk domain
	input  wire                        i_wclk,
	input  wire                        i_wr_reset_n,
	input  wire                        i_wr,
	input  wire async_fifo_pkg::data_t i_wr_data,
	output logic                       o_wr_full,
	// Read side in the gbl_clk domain
	input  wire                        gbl_clk,
	input  wire                        i_rd_reset_n,
	input  wire                        i_rd,
	output async_fifo_pkg::data_t      o_rd_data,
	output logic                       o_rd_empty
);

	import async_fifo_pkg::*;

	// Write controller to storage
	mem_wr_t mem_wr;

	// Read controller and storage
	addr_t ram_addr;
	data_t ram_data;

	// Gray pointers before and after their crossing
	ptr_t wgray;
	ptr_t wgray_sync;
	ptr_t rgray;
	ptr_t rgray_sync;

	////////////////////////////////////////////////////////////
	// Write domain
	////////////////////////////////////////////////////////////

	fifo_wr_ctrl i_fifo_wr_ctrl (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.i_rgray_sync (rgray_sync),
		.o_wr_full    (o_wr_full),
		.o_mem_wr     (mem_wr),
		.o_wgray      (wgray)
	);

	// Read pointer brought into the write domain
	gray_ptr_sync i_rgray_to_wr (
		.i_clk     (i_wclk),
		.i_reset_n (i_wr_reset_n),
		.i_gray    (rgray),
		.o_gray    (rgray_sync)
	);

	// Storage sits on the write clock
	fifo_ram i_fifo_ram (
		.i_wclk    (i_wclk),
		.i_mem_wr  (mem_wr),
		.i_rd_addr (ram_addr),
		.o_rd_data (ram_data)
	);

	////////////////////////////////////////////////////////////
	// Read domain
	////////////////////////////////////////////////////////////

	// Write pointer brought into the read domain
	gray_ptr_sync i_wgray_to_rd (
		.i_clk     (gbl_clk),
		.i_reset_n (i_rd_reset_n),
		.i_gray    (wgray),
		.o_gray    (wgray_sync)
	);

	fifo_rd_ctrl i_fifo_rd_ctrl (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.i_wgray_sync (wgray_sync),
		.i_ram_data   (ram_data),
		.o_ram_addr   (ram_addr),
		.o_rgray      (rgray),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

endmodule

`default_nettype wire

// File: bench/async_fifo_props.sv
////////////////////////////////////////////////////////////
// Concurrent checks on the dual-clock FIFO top level
// Bound into every async_fifo by the bind at the end
// Failures also bump a counter that the bench reads at the end
////////////////////////////////////////////////////////////

`default_nettype none

module async_fifo_props (
	// Write domain
	input wire                        i_wclk,
	input wire                        i_wr_reset_n,
	input wire async_fifo_pkg::ptr_t  i_wgray,
	// Read domain
	input wire                        gbl_clk,
	input wire                        i_rd_reset_n,
	input wire                        i_rd,
	input wire async_fifo_pkg::data_t i_rd_data,
	input wire                        i_rd_empty,
	input wire async_fifo_pkg::ptr_t  i_rgray
);

	timeunit 1ns;
	timeprecision 1ps;

	// Number of failed assertions
	int assert_fails = 0;

	// Gray write pointer moves by one bit at most
	wgray_one_bit: assert property (
		@(posedge i_wclk) disable iff (!i_wr_reset_n)
		$countones(i_wgray ^ $past(i_wgray)) <= 1
	) else begin
		assert_fails++;
		$error("Gray write pointer changed more than one bit");
	end

	// Same rule for the Gray read pointer
	rgray_one_bit: assert property (
		@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		$countones(i_rgray ^ $past(i_rgray)) <= 1
	) else begin
		assert_fails++;
		$error("Gray read pointer changed more than one bit");
	end

	// Output word holds while the reader waits
	rd_data_hold: assert property (
		@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(!i_rd_empty && !i_rd) |=> $stable(i_rd_data)
	) else begin
		assert_fails++;
		$error("Output word changed without a read");
	end

	// First cycle out of reset shows an empty FIFO
	empty_after_reset: assert property (
		@(posedge gbl_clk) $rose(i_rd_reset_n) |-> i_rd_empty
	) else begin
		assert_fails++;
		$error("Empty flag low right after reset");
	end

endmodule

bind async_fifo async_fifo_props i_async_fifo_props (
	.i_wclk       (i_wclk),
	.i_wr_reset_n (i_wr_reset_n),
	.i_wgray      (wgray),
	.gbl_clk      (gbl_clk),
	.i_rd_reset_n (i_rd_reset_n),
	.i_rd         (i_rd),
	.i_rd_data    (o_rd_data),
	.i_rd_empty   (o_rd_empty),
	.i_rgray      (rgray)
);

`default_nettype wire

// File: bench/tb_async_fifo.sv
////////////////////////////////////////////////////////////
// Testbench for the dual-clock FIFO
// Applies a table of traffic phases on two unrelated clocks
// A queue of accepted writes is the scoreboard for every read
////////////////////////////////////////////////////////////

`default_nettype none

module tb_async_fifo;

	timeunit 1ns;
	timeprecision 1ps;

	import async_fifo_pkg::*;

	localparam int NUM_PHASES = 5;

	// One traffic phase, counts are clock cycles on each side
	typedef struct packed {
		logic [7:0] wr_cnt;
		logic [7:0] rd_cnt;
		logic [6:0] wr_pct;
		logic [6:0] rd_pct;
		logic       must_full;
	} phase_t;

	string phase_name [NUM_PHASES] =
		'{"order", "fill_drop", "empty_read", "random_a", "random_b"};

	// Writes, reads, write %, read %, full must show
	phase_t phases [NUM_PHASES] = '{
		'{6, 0, 40, 0, 0},
		'{FIFO_DEPTH + 3, 0, 100, 0, 1},
		'{0, 30, 0, 100, 0},
		'{60, 80, 70, 60, 0},
		'{60, 80, 40, 90, 0}
	};

	// DUT ports
	logic  gbl_clk;
	logic  i_wclk;
	logic  i_rd_reset_n;
	logic  i_wr_reset_n;
	logic  i_wr;
	data_t i_wr_data;
	logic  o_wr_full;
	logic  i_rd;
	data_t o_rd_data;
	logic  o_rd_empty;

	// Scoreboard and bookkeeping
	data_t      wr_q [$];
	data_t      exp_word;
	string      cur_phase = "reset";
	int         err_cnt = 0;
	int         check_cnt = 0;
	int         cycle_cnt = 0;
	int         cycle_limit = 0;
	logic       full_seen = 1'b0;
	logic [7:0] wr_seq = 8'd0;

	async_fifo i_async_fifo (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.o_wr_full    (o_wr_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

	////////////////////////////////////////////////////////////
	// Clocks, monitors and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		gbl_clk = 1'b0;
		forever #10 gbl_clk = ~gbl_clk;
	end

	// 14 ns, unrelated to the read clock
	initial
	begin
		i_wclk = 1'b0;
		forever #7 i_wclk = ~i_wclk;
	end

	// Accepted writes enter the queue, refused ones mark full
	always @(posedge i_wclk)
	begin
		if (i_wr_reset_n && i_wr)
		begin
			if (o_wr_full)
				full_seen = 1'b1;
			else
				wr_q.push_back(i_wr_data);
		end
	end

	// Each consumed word must match the oldest accepted write
	always @(posedge gbl_clk)
	begin
		if (i_rd_reset_n && i_rd && !o_rd_empty)
		begin
			check_cnt++;
			if (wr_q.size() == 0)
			begin
				$display("Phase %s read a word although no write was pending", cur_phase);
				err_cnt++;
			end
			else
			begin
				exp_word = wr_q.pop_front();
				if (o_rd_data !== exp_word)
				begin
					$display("ERR %s expected %h actual %h", cur_phase, exp_word, o_rd_data);
					err_cnt++;
				end
			end
		end
	end

	// Limit from the table size
	always @(posedge gbl_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
		begin
			$display("Timeout in phase %s, the FIFO stopped moving data", cur_phase);
			$display("Checks: %0d, errors: %0d", check_cnt, err_cnt + 1);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Traffic tasks
	////////////////////////////////////////////////////////////

	// Write strobes at the given rate, sequence number in the low byte
	task automatic drive_writes(input int count, input int pct);
		data_t word;
		for (int i = 0; i < count; i++)
		begin
			@(posedge i_wclk);
			word = data_t'($urandom);
			word[7:0] = wr_seq;
			wr_seq = wr_seq + 8'd1;
			if ($urandom_range(99) < pct)
			begin
				i_wr      <= 1'b1;
				i_wr_data <= word;
			end
			else
				i_wr <= 1'b0;
		end
		@(posedge i_wclk);
		i_wr <= 1'b0;
	endtask

	task automatic drive_reads(input int count, input int pct);
		for (int i = 0; i < count; i++)
		begin
			@(posedge gbl_clk);
			i_rd <= ($urandom_range(99) < pct);
		end
		@(posedge gbl_clk);
		i_rd <= 1'b0;
	endtask

	// Read until the empty flag stays high longer than the crossing delay
	task automatic drain_fifo();
		int quiet;
		quiet = 0;
		@(posedge gbl_clk);
		i_rd <= 1'b1;
		while (quiet < SYNC_STAGES + 2)
		begin
			@(negedge gbl_clk);
			if (o_rd_empty)
				quiet++;
			else
				quiet = 0;
		end
		@(posedge gbl_clk);
		i_rd <= 1'b0;
		@(negedge gbl_clk);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int seed;
		int total_words;
		i_rd_reset_n = 1'b0;
		i_wr_reset_n = 1'b0;
		i_wr         = 1'b0;
		i_wr_data    = '0;
		i_rd         = 1'b0;
		seed         = 32'h4f8a;
		void'($urandom(seed));
		total_words = 0;
		for (int p = 0; p < NUM_PHASES; p++)
			total_words += phases[p].wr_cnt + phases[p].rd_cnt;
		cycle_limit = 40 * total_words;

		repeat (3) @(posedge gbl_clk);
		i_rd_reset_n <= 1'b1;
		i_wr_reset_n <= 1'b1;
		@(negedge gbl_clk);
		check_cnt += 2;
		if (o_rd_empty !== 1'b1)
		begin
			$display("ERR %s o_rd_empty expected 1 actual %b", cur_phase, o_rd_empty);
			err_cnt++;
		end
		if (o_wr_full !== 1'b0)
		begin
			$display("ERR %s o_wr_full expected 0 actual %b", cur_phase, o_wr_full);
			err_cnt++;
		end

		for (int p = 0; p < NUM_PHASES; p++)
		begin
			cur_phase = phase_name[p];
			full_seen = 1'b0;
			fork
				drive_writes(phases[p].wr_cnt, phases[p].wr_pct);
				drive_reads(phases[p].rd_cnt, phases[p].rd_pct);
			join
			drain_fifo();
			check_cnt += 2;
			if (phases[p].must_full && !full_seen)
			begin
				$display("ERR %s o_wr_full_seen expected 1 actual 0", cur_phase);
				err_cnt++;
			end
			// Drained FIFO shows empty with nothing left to expect
			if (o_rd_empty !== 1'b1 || wr_q.size() != 0)
			begin
				$display("ERR %s empty/queue expected 1/0 actual %b/%0d",
					cur_phase, o_rd_empty, wr_q.size());
				err_cnt++;
			end
		end

		err_cnt += i_async_fifo.i_async_fifo_props.assert_fails;
		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
source/async_fifo_pkg.sv
source/gray_ptr_sync.sv
source/fifo_ram.sv
source/fifo_wr_ctrl.sv
source/fifo_rd_ctrl.sv
source/async_fifo.sv
bench/async_fifo_props.sv
bench/tb_async_fifo.sv

// File: Bender.yml
package:
  name: async_fifo

sources:
  - files:
      - source/async_fifo_pkg.sv
      - source/gray_ptr_sync.sv
      - source/fifo_ram.sv
      - source/fifo_wr_ctrl.sv
      - source/fifo_rd_ctrl.sv
      - source/async_fifo.sv
  - target: test
    files:
      - bench/async_fifo_props.sv
      - bench/tb_async_fifo.sv
